// File: Makefile
# Verilator build and run for the convolution core testbench

VERILATOR ?= verilator
TOP       ?= qracc_tb
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/act_buffer.sv
//////////////////////////////////////////////////////////////////////
// Byte activation memory; ports are never driven at the same address
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module act_buffer (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     ext_wr_en_i,
    input  logic [`QRACC_ADDR_W-3:0] ext_wr_addr_i,
    input  logic [`QRACC_BUS_W-1:0]  wr_data_i,
    input  logic [`QRACC_ADDR_W-1:0] int_rd_addr_i,
    input  logic                     res_valid_i,
    input  logic [`QRACC_ADDR_W-1:0] out_wr_addr_i,
    input  logic [7:0]               res_data_i,
    input  logic                     ext_rd_en_i,
    input  logic [`QRACC_ADDR_W-1:0] ext_rd_addr_i,
    output logic [7:0]               int_rd_data_o,
    output logic [`QRACC_BUS_W-1:0]  rd_data_o,
    output logic                     rd_valid_o
);

    localparam int BW = `QRACC_BUS_W;

    logic [7:0] mem [`QRACC_BUF_DEPTH];
    logic [7:0] rd_byte_q;

    always_ff @(posedge clk) begin : mem_ports
        // Packed host word, pixel address is word pointer times 4
        if (ext_wr_en_i) begin
            for (int i = 0; i < BW / 8; i++) begin
                mem[{ext_wr_addr_i, 2'(i)}] <= wr_data_i[8*i +: 8];
            end
        end
        // Requantized result from the MAC
        if (res_valid_i) mem[out_wr_addr_i] <= res_data_i;
        // Tap fetch, one cycle latency
        int_rd_data_o <= mem[int_rd_addr_i];
        if (ext_rd_en_i) rd_byte_q <= mem[ext_rd_addr_i];
    end

    always_ff @(posedge clk or negedge nrst) begin : rd_valid_reg
        if (!nrst) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= ext_rd_en_i;
        end
    end

    // Zero-extended output byte
    assign rd_data_o = BW'(rd_byte_q);

endmodule

// File: logic/mac_unit.sv
//////////////////////////////////////////////////////////////////////
// Single-lane MAC; unsigned pixels, signed weights, 20-bit sum
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module mac_unit import qracc_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  bus_word_u               wr_data_i,
    input  logic                    w_wr_en_i,
    input  logic [1:0]              w_idx_i,
    input  logic                    s_wr_en_i,
    input  logic [`QRACC_TAP_W-1:0] tap_i,
    input  logic                    tap_valid_i,
    input  logic                    last_tap_i,
    input  logic [7:0]              act_i,
    output logic                    res_valid_o,
    output logic [7:0]              res_data_o
);

    localparam int NT = `QRACC_W_WORDS * 4;

    weight_t                 w_q [NT];
    logic [4:0]              shift_q;
    logic [`QRACC_TAP_W-1:0] tap_d;
    logic                    valid_d;
    logic                    last_d;
    logic signed [16:0]      prod;
    logic signed [19:0]      acc_q;
    logic signed [19:0]      acc_sh;

    always_ff @(posedge clk) begin : coef_regs
        if (w_wr_en_i) begin
            for (int i = 0; i < 4; i++) begin
                w_q[{w_idx_i, 2'(i)}] <= wr_data_i.taps[i];
            end
        end
        if (s_wr_en_i) shift_q <= wr_data_i.s.shift;
    end

    // Tap info lines up with the buffer read data
    always_ff @(posedge clk or negedge nrst) begin : tap_pipe
        if (!nrst) begin
            tap_d       <= '0;
            valid_d     <= 1'b0;
            last_d      <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            tap_d       <= tap_i;
            valid_d     <= tap_valid_i;
            last_d      <= tap_valid_i && last_tap_i;
            res_valid_o <= valid_d && last_d;
        end
    end

    assign prod = 17'($signed({1'b0, act_i})) * 17'(w_q[tap_d]);

    // Tap 0 restarts the sum
    always_ff @(posedge clk) begin : acc_reg
        if (valid_d) acc_q <= ((tap_d == '0) ? 20'sd0 : acc_q) + 20'(prod);
    end

    assign acc_sh = acc_q >>> shift_q;

    always_comb begin : requant
        if (acc_sh < 20'sd0) begin
            res_data_o = 8'd0;
        end else if (acc_sh > 20'sd255) begin
            res_data_o = 8'hff;
        end else begin
            res_data_o = acc_sh[7:0];
        end
    end

endmodule

// File: logic/qracc_cfg.svh
//////////////////////////////////////////////////////////////////////
// Sizes of the core; ifmap plus ofmap must fit in the buffer
//////////////////////////////////////////////////////////////////////
`ifndef QRACC_CFG_SVH
`define QRACC_CFG_SVH

// Host bus
`define QRACC_BUS_W 32

// Activation buffer in bytes
`define QRACC_BUF_DEPTH 256
`define QRACC_ADDR_W $clog2(`QRACC_BUF_DEPTH)

// Layer geometry, side lengths up to 15
`define QRACC_DIM_W 4
`define QRACC_MAX_FSIZE 3
`define QRACC_FS_W $clog2(`QRACC_MAX_FSIZE + 1)

// Weight store, four taps per word
`define QRACC_W_WORDS 3
`define QRACC_TAP_W $clog2(`QRACC_W_WORDS * 4)

`endif

// File: logic/qracc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types of the convolution core; the bus word is one 32-bit word
//////////////////////////////////////////////////////////////////////
`include "qracc_cfg.svh"

package qracc_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        S_IDLE        = 3'd0,
        S_LOADACTS    = 3'd1,
        S_LOADWEIGHTS = 3'd2,
        S_LOADSCALER  = 3'd3,
        S_COMPUTE     = 3'd4,
        S_READACTS    = 3'd5
    } state_t;

    // Host commands, only looked at while idle
    typedef enum logic [2:0] {
        TRIGGER_IDLE            = 3'd0,
        TRIGGER_LOAD_ACTIVATION = 3'd1,
        TRIGGER_LOAD_WEIGHTS    = 3'd2,
        TRIGGER_COMPUTE         = 3'd3,
        TRIGGER_READ_ACTIVATION = 3'd4
    } trigger_t;

    typedef logic signed [7:0] weight_t;

    // Scaler word, shift in the low bits
    typedef struct packed {
        logic [`QRACC_BUS_W-6:0] rsvd;
        logic [4:0]              shift;
    } scaler_word_t;

    // One bus word, either four taps (tap 0 low) or the scaler
    typedef union packed {
        weight_t [3:0] taps;
        scaler_word_t  s;
    } bus_word_u;

endpackage

// File: logic/qracc_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Mode sequencer; layer sizes must not change while busy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_sequencer import qracc_pkg::*; (
    input  logic                     clk,
    input  logic                     nrst,
    input  trigger_t                 trigger_i,
    input  logic                     clear_i,
    input  logic [`QRACC_DIM_W-1:0]  dimx_i,
    input  logic [`QRACC_DIM_W-1:0]  dimy_i,
    input  logic [`QRACC_FS_W-1:0]   fsize_i,
    input  logic                     wr_valid_i,
    input  logic                     done_i,
    output logic                     ready_o,
    output logic                     busy_o,
    output state_t                   state_o,
    output logic                     ext_wr_en_o,
    output logic [`QRACC_ADDR_W-3:0] ext_wr_addr_o,
    output logic                     ext_rd_en_o,
    output logic [`QRACC_ADDR_W-1:0] ext_rd_addr_o,
    output logic                     w_wr_en_o,
    output logic [1:0]               w_idx_o,
    output logic                     s_wr_en_o,
    output logic                     start_o
);

    localparam int AW = `QRACC_ADDR_W;
    localparam int WW = AW - 2;
    localparam int DW = `QRACC_DIM_W;

    state_t          state_q;
    state_t          state_d;
    logic [WW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            start_q;
    logic            wr_fire;
    logic [AW-1:0]   ifmap_size;
    logic [AW-1:0]   ofmap_size;
    logic [DW-1:0]   odimx;
    logic [DW-1:0]   odimy;
    logic [WW-1:0]   last_word;

    // Layer geometry
    assign ifmap_size = AW'(dimx_i) * AW'(dimy_i);
    assign odimx      = dimx_i - DW'(fsize_i) + DW'(1);
    assign odimy      = dimy_i - DW'(fsize_i) + DW'(1);
    assign ofmap_size = AW'(odimx) * AW'(odimy);
    // Four pixels per word, partial last word
    assign last_word  = WW'((ifmap_size + AW'(3)) >> 2) - WW'(1);

    assign wr_fire       = wr_valid_i && ready_o;
    assign busy_o        = (state_q != S_IDLE);
    assign state_o       = state_q;
    assign start_o       = start_q;
    assign ext_wr_addr_o = wr_ptr;
    assign w_idx_o       = wr_ptr[1:0];
    // Ofmap sits right behind the ifmap
    assign ext_rd_addr_o = ifmap_size + rd_ptr;

    //////////////////////////////////////////////////////////////////////
    // State register and pointers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin : state_regs
        if (!nrst) begin
            state_q <= S_IDLE;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= (state_q == S_IDLE) && (state_d == S_COMPUTE);
            // Word pointer lives only inside one load state
            if (state_q == S_IDLE || state_d != state_q) begin
                wr_ptr <= '0;
            end else if (wr_fire) begin
                wr_ptr <= wr_ptr + WW'(1);
            end
            if (state_q == S_READACTS && state_d == S_READACTS) begin
                rd_ptr <= rd_ptr + AW'(1);
            end else begin
                rd_ptr <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Strobe decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin : out_decode
        ready_o     = 1'b0;
        ext_wr_en_o = 1'b0;
        ext_rd_en_o = 1'b0;
        w_wr_en_o   = 1'b0;
        s_wr_en_o   = 1'b0;
        case (state_q)
            S_IDLE: begin
                ready_o = 1'b1;
            end
            S_LOADACTS: begin
                ready_o     = 1'b1;
                ext_wr_en_o = wr_valid_i;
            end
            S_LOADWEIGHTS: begin
                ready_o   = 1'b1;
                w_wr_en_o = wr_valid_i;
            end
            S_LOADSCALER: begin
                ready_o   = 1'b1;
                s_wr_en_o = wr_valid_i;
            end
            S_READACTS: begin
                ext_rd_en_o = 1'b1;
            end
            default: begin
                ready_o = 1'b0;
            end
        endcase
    end

    always_comb begin : next_decode
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                case (trigger_i)
                    TRIGGER_LOAD_ACTIVATION: state_d = S_LOADACTS;
                    TRIGGER_LOAD_WEIGHTS:    state_d = S_LOADWEIGHTS;
                    TRIGGER_COMPUTE:         state_d = S_COMPUTE;
                    TRIGGER_READ_ACTIVATION: state_d = S_READACTS;
                    default:                 state_d = S_IDLE;
                endcase
            end
            S_LOADACTS: begin
                if (wr_fire && wr_ptr == last_word) state_d = S_IDLE;
            end
            S_LOADWEIGHTS: begin
                if (wr_fire && wr_ptr == WW'(`QRACC_W_WORDS - 1)) state_d = S_LOADSCALER;
            end
            S_LOADSCALER: begin
                if (wr_fire) state_d = S_IDLE;
            end
            S_COMPUTE: begin
                if (done_i) state_d = S_IDLE;
            end
            S_READACTS: begin
                if (rd_ptr == ofmap_size - AW'(1)) state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
        // Clear wins over everything
        if (clear_i) state_d = S_IDLE;
    end

endmodule

// File: logic/qracc_top.sv
//////////////////////////////////////////////////////////////////////
// Convolution core; host waits on ready_o, no other back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_top import qracc_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  trigger_t                trigger_i,
    input  logic                    clear_i,
    input  logic [`QRACC_DIM_W-1:0] dimx_i,
    input  logic [`QRACC_DIM_W-1:0] dimy_i,
    input  logic [`QRACC_FS_W-1:0]  fsize_i,
    input  logic                    wr_valid_i,
    input  logic [`QRACC_BUS_W-1:0] wr_data_i,
    output logic                    ready_o,
    output logic [`QRACC_BUS_W-1:0] rd_data_o,
    output logic                    rd_valid_o,
    output logic                    busy_o,
    output state_t                  state_o
);

    logic                     ext_wr_en;
    logic [`QRACC_ADDR_W-3:0] ext_wr_addr;
    logic                     ext_rd_en;
    logic [`QRACC_ADDR_W-1:0] ext_rd_addr;
    logic                     w_wr_en;
    logic [1:0]               w_idx;
    logic                     s_wr_en;
    logic                     start;
    logic                     done;
    logic [`QRACC_ADDR_W-1:0] int_rd_addr;
    logic [`QRACC_TAP_W-1:0]  tap;
    logic                     tap_valid;
    logic                     last_tap;
    logic [`QRACC_ADDR_W-1:0] out_wr_addr;
    logic [7:0]               int_rd_data;
    logic                     res_valid;
    logic [7:0]               res_data;

    qracc_sequencer u_seq (
        .clk, .nrst, .trigger_i, .clear_i, .dimx_i, .dimy_i, .fsize_i, .wr_valid_i,
        .done_i(done), .ready_o, .busy_o, .state_o,
        .ext_wr_en_o(ext_wr_en), .ext_wr_addr_o(ext_wr_addr),
        .ext_rd_en_o(ext_rd_en), .ext_rd_addr_o(ext_rd_addr),
        .w_wr_en_o(w_wr_en), .w_idx_o(w_idx), .s_wr_en_o(s_wr_en), .start_o(start)
    );

    window_counter u_win (
        .clk, .nrst, .start_i(start), .clear_i, .dimx_i, .dimy_i, .fsize_i,
        .int_rd_addr_o(int_rd_addr), .tap_o(tap), .tap_valid_o(tap_valid),
        .last_tap_o(last_tap), .out_wr_addr_o(out_wr_addr), .done_o(done)
    );

    act_buffer u_buf (
        .clk, .nrst, .ext_wr_en_i(ext_wr_en), .ext_wr_addr_i(ext_wr_addr), .wr_data_i,
        .int_rd_addr_i(int_rd_addr), .res_valid_i(res_valid), .out_wr_addr_i(out_wr_addr),
        .res_data_i(res_data), .ext_rd_en_i(ext_rd_en), .ext_rd_addr_i(ext_rd_addr),
        .int_rd_data_o(int_rd_data), .rd_data_o, .rd_valid_o
    );

    mac_unit u_mac (
        .clk, .nrst, .wr_data_i, .w_wr_en_i(w_wr_en), .w_idx_i(w_idx), .s_wr_en_i(s_wr_en),
        .tap_i(tap), .tap_valid_i(tap_valid), .last_tap_i(last_tap), .act_i(int_rd_data),
        .res_valid_o(res_valid), .res_data_o(res_data)
    );

endmodule

// File: logic/window_counter.sv
//////////////////////////////////////////////////////////////////////
// Walks windows at stride 1, one tap per cycle; no stalls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module window_counter (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     start_i,
    input  logic                     clear_i,
    input  logic [`QRACC_DIM_W-1:0]  dimx_i,
    input  logic [`QRACC_DIM_W-1:0]  dimy_i,
    input  logic [`QRACC_FS_W-1:0]   fsize_i,
    output logic [`QRACC_ADDR_W-1:0] int_rd_addr_o,
    output logic [`QRACC_TAP_W-1:0]  tap_o,
    output logic                     tap_valid_o,
    output logic                     last_tap_o,
    output logic [`QRACC_ADDR_W-1:0] out_wr_addr_o,
    output logic                     done_o
);

    localparam int AW = `QRACC_ADDR_W;
    localparam int DW = `QRACC_DIM_W;
    localparam int FW = `QRACC_FS_W;
    localparam int TW = `QRACC_TAP_W;

    logic          running_q;
    logic [DW-1:0] ox_q;
    logic [DW-1:0] oy_q;
    logic [FW-1:0] fx_q;
    logic [FW-1:0] fy_q;
    logic [TW-1:0] tap_q;
    logic [AW-1:0] out_idx_q;
    logic [1:0]    lst_q;
    logic [2:0]    fin_q;
    logic [DW-1:0] odimx;
    logic [DW-1:0] odimy;
    logic [FW-1:0] flast;
    logic          fx_end;
    logic          fy_end;
    logic          ox_end;
    logic          oy_end;
    logic          final_tap;

    assign flast  = fsize_i - FW'(1);
    assign odimx  = dimx_i - DW'(fsize_i) + DW'(1);
    assign odimy  = dimy_i - DW'(fsize_i) + DW'(1);
    assign fx_end = (fx_q == flast);
    assign fy_end = (fy_q == flast);
    assign ox_end = (ox_q == odimx - DW'(1));
    assign oy_end = (oy_q == odimy - DW'(1));

    assign tap_valid_o = running_q;
    assign tap_o       = tap_q;
    assign last_tap_o  = running_q && fx_end && fy_end;
    assign final_tap   = last_tap_o && ox_end && oy_end;
    assign done_o      = fin_q[2];

    // (oy+fy)*dimx + ox + fx
    assign int_rd_addr_o = AW'(oy_q + DW'(fy_q)) * AW'(dimx_i) + AW'(ox_q) + AW'(fx_q);
    assign out_wr_addr_o = AW'(dimx_i) * AW'(dimy_i) + out_idx_q;

    always_ff @(posedge clk or negedge nrst) begin : walk
        if (!nrst) begin
            running_q <= 1'b0;
            {ox_q, oy_q, fx_q, fy_q, tap_q} <= '0;
            out_idx_q <= '0;
            lst_q     <= '0;
            fin_q     <= '0;
        end else if (clear_i || start_i) begin
            running_q <= start_i && !clear_i;
            {ox_q, oy_q, fx_q, fy_q, tap_q} <= '0;
            out_idx_q <= '0;
            lst_q     <= '0;
            fin_q     <= '0;
        end else begin
            // Results land two cycles after their last tap
            lst_q <= {lst_q[0], last_tap_o};
            fin_q <= {fin_q[1:0], final_tap};
            if (lst_q[1]) out_idx_q <= out_idx_q + AW'(1);
            if (running_q) begin
                tap_q <= last_tap_o ? '0 : tap_q + TW'(1);
                fx_q  <= fx_end ? '0 : fx_q + FW'(1);
                if (fx_end) fy_q <= fy_end ? '0 : fy_q + FW'(1);
                if (fx_end && fy_end) begin
                    ox_q <= ox_end ? '0 : ox_q + DW'(1);
                    if (ox_end) oy_q <= oy_end ? '0 : oy_q + DW'(1);
                end
                if (final_tap) running_q <= 1'b0;
            end
        end
    end

endmodule

// File: sources.f
+incdir+logic
logic/qracc_pkg.sv
logic/qracc_sequencer.sv
logic/window_counter.sv
logic/act_buffer.sv
logic/mac_unit.sv
logic/qracc_top.sv
testbench/qracc_props.sv
testbench/qracc_tb.sv

// File: testbench/qracc_props.sv
//////////////////////////////////////////////////////////////////////
// Sequencer checks, bound into every qracc_sequencer instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module qracc_props import qracc_pkg::*; (
    input logic     clk,
    input logic     nrst,
    input logic     ready_o,
    input logic     start_o,
    input logic     busy_o,
    input state_t   state_o,
    input trigger_t trigger_i
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Host is never ready while compute starts
    ready_start_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(ready_o && start_o))
    else begin
        $error("ready_o and start_o high together");
        fail_count++;
    end

    busy_matches_state: assert property (@(posedge clk) disable iff (!nrst)
        busy_o == (state_o != S_IDLE))
    else begin
        $error("busy_o does not follow the state");
        fail_count++;
    end

    // Idle trigger keeps the FSM idle
    idle_needs_trigger: assert property (@(posedge clk) disable iff (!nrst)
        (state_o == S_IDLE && trigger_i == TRIGGER_IDLE) |=> (state_o == S_IDLE))
    else begin
        $error("state left idle without a trigger");
        fail_count++;
    end

endmodule

bind qracc_sequencer qracc_props u_props (
    .clk(clk),
    .nrst(nrst),
    .ready_o(ready_o),
    .start_o(start_o),
    .busy_o(busy_o),
    .state_o(state_o),
    .trigger_i(trigger_i)
);

// File: testbench/qracc_tb.sv
//////////////////////////////////////////////////////////////////////
// Random layers checked against a convolution model; seed is fixed
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_tb import qracc_pkg::*; ();

    localparam int DW = `QRACC_DIM_W;
    localparam int FW = `QRACC_FS_W;
    localparam int DIM_MAX = 10;
    localparam int NTAPS = `QRACC_W_WORDS * 4;
    // Nine layer runs that each take at most a full 3x3 compute plus load and read
    localparam int RUNS = 9;
    localparam int CYCLE_LIMIT = RUNS * (DIM_MAX * DIM_MAX * 9 + 200);

    logic                    clk;
    logic                    nrst;
    trigger_t                trigger;
    logic                    clear;
    logic [DW-1:0]           dimx;
    logic [DW-1:0]           dimy;
    logic [FW-1:0]           fsize;
    logic                    wr_valid;
    logic [`QRACC_BUS_W-1:0] wr_data;
    logic                    ready;
    logic [`QRACC_BUS_W-1:0] rd_data;
    logic                    rd_valid;
    logic                    busy;
    state_t                  state;

    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int tests_failed;
    int cycle_cnt = 0;
    // Current layer
    int dx;
    int dy;
    int fs;
    int shift;
    int act [DIM_MAX * DIM_MAX];
    int wt [NTAPS];
    logic [31:0] word_q [$];

    qracc_top DUT (
        .clk(clk), .nrst(nrst), .trigger_i(trigger), .clear_i(clear),
        .dimx_i(dimx), .dimy_i(dimy), .fsize_i(fsize),
        .wr_valid_i(wr_valid), .wr_data_i(wr_data), .ready_o(ready),
        .rd_data_o(rd_data), .rd_valid_o(rd_valid), .busy_o(busy), .state_o(state)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: DUT did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Mode 0 random, 1 all weights +127, 2 all weights -128
    task automatic draw_layer(input int mode);
        fs = int'($urandom % 3) + 1;
        dx = fs + 1 + int'($urandom % (DIM_MAX - fs));
        dy = fs + 1 + int'($urandom % (DIM_MAX - fs));
        shift = (mode == 0) ? int'($urandom % 8) : 0;
        for (int i = 0; i < dx * dy; i++) begin
            act[i] = (mode == 0) ? int'($urandom % 256) : 128 + int'($urandom % 128);
        end
        for (int t = 0; t < NTAPS; t++) begin
            if (mode == 1) wt[t] = 127;
            else if (mode == 2) wt[t] = -128;
            else wt[t] = int'($urandom % 256) - 128;
        end
    endtask

    // Reference convolution, shift and clip for one output pixel
    function automatic int expected_byte(input int idx);
        int odx;
        int ox;
        int oy;
        int sum;
        odx = dx - fs + 1;
        ox = idx % odx;
        oy = idx / odx;
        sum = 0;
        for (int fy = 0; fy < fs; fy++) begin
            for (int fx = 0; fx < fs; fx++) begin
                sum += act[(oy + fy) * dx + ox + fx] * wt[fy * fs + fx];
            end
        end
        sum = sum >>> shift;
        if (sum < 0) return 0;
        if (sum > 255) return 255;
        return sum;
    endfunction

    task automatic send_trigger(input trigger_t code);
        @(posedge clk);
        #2;
        trigger = code;
        @(posedge clk);
        #2;
        trigger = TRIGGER_IDLE;
    endtask

    task automatic write_queue();
        foreach (word_q[i]) begin
            wr_valid = 1'b1;
            wr_data = word_q[i];
            @(posedge clk);
            #2;
        end
        wr_valid = 1'b0;
    endtask

    task automatic load_layer();
        logic [31:0] w;
        int p;
        dimx = DW'(dx);
        dimy = DW'(dy);
        fsize = FW'(fs);
        // Four pixels per word with pixel 0 in the low byte
        word_q.delete();
        for (int k = 0; k < (dx * dy + 3) / 4; k++) begin
            for (int b = 0; b < 4; b++) begin
                p = 4 * k + b;
                w[8*b +: 8] = (p < dx * dy) ? 8'(act[p]) : 8'($urandom);
            end
            word_q.push_back(w);
        end
        send_trigger(TRIGGER_LOAD_ACTIVATION);
        write_queue();
        // Three weight words, then the scaler with junk in the reserved bits
        word_q.delete();
        for (int k = 0; k < `QRACC_W_WORDS; k++) begin
            for (int b = 0; b < 4; b++) begin
                w[8*b +: 8] = 8'(wt[4 * k + b]);
            end
            word_q.push_back(w);
        end
        w = $urandom;
        w[4:0] = 5'(shift);
        word_q.push_back(w);
        send_trigger(TRIGGER_LOAD_WEIGHTS);
        write_queue();
    endtask

    task automatic run_compute(input bit noise);
        send_trigger(TRIGGER_COMPUTE);
        while (busy) begin
            if (noise) begin
                wr_valid = 1'b1;
                wr_data = $urandom;
            end
            @(posedge clk);
            #2;
        end
        wr_valid = 1'b0;
    endtask

    task automatic read_check();
        int n;
        int got;
        n = (dx - fs + 1) * (dy - fs + 1);
        got = 0;
        send_trigger(TRIGGER_READ_ACTIVATION);
        while (got < n) begin
            @(negedge clk);
            if (rd_valid) begin
                check($sformatf("rd_data_o[%0d]", got), rd_data, expected_byte(got));
                got++;
            end
        end
        @(negedge clk);
        check("rd_valid_o", 32'(rd_valid), 0);
        @(posedge clk);
        #2;
    endtask

    task automatic run_layer(input bit noise);
        load_layer();
        run_compute(noise);
        read_check();
    endtask

    task automatic end_test(input string title);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests_run, title);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d mismatches", tests_run, title, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin : main
        int prev_dx;
        int prev_dy;
        int prev_fs;
        void'($urandom(41));
        {errors, checks, test_errors, tests_run, tests_failed} = '0;
        clk = 1'b0;
        nrst = 1'b0;
        trigger = TRIGGER_IDLE;
        clear = 1'b0;
        dimx = '0;
        dimy = '0;
        fsize = FW'(1);
        wr_valid = 1'b0;
        wr_data = '0;
        repeat (3) @(posedge clk);
        #2;
        nrst = 1'b1;

        @(negedge clk);
        check("busy_o", 32'(busy), 0);
        check("rd_valid_o", 32'(rd_valid), 0);
        check("ready_o", 32'(ready), 1);
        check("state_o", 32'(state), 32'(S_IDLE));
        @(posedge clk);
        #2;
        end_test("reset state");

        draw_layer(0);
        run_layer(1'b0);
        end_test("random layer");

        draw_layer(0);
        run_layer(1'b1);
        end_test("writes ignored during compute");

        draw_layer(1);
        run_layer(1'b0);
        draw_layer(2);
        run_layer(1'b0);
        end_test("saturation extremes");

        // Abort a compute part way, then redo it
        draw_layer(0);
        load_layer();
        send_trigger(TRIGGER_COMPUTE);
        repeat (4) begin
            @(posedge clk);
            #2;
        end
        check("busy_o", 32'(busy), 1);
        clear = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("busy_o", 32'(busy), 0);
        @(posedge clk);
        #2;
        clear = 1'b0;
        run_compute(1'b0);
        read_check();
        end_test("clear during compute");

        prev_dx = 0;
        prev_dy = 0;
        prev_fs = 0;
        for (int k = 0; k < 3; k++) begin
            draw_layer(0);
            while (dx == prev_dx && dy == prev_dy && fs == prev_fs) draw_layer(0);
            prev_dx = dx;
            prev_dy = dy;
            prev_fs = fs;
            run_layer(1'b0);
        end
        end_test("back to back layers");

        errors += DUT.u_seq.u_props.fail_count;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, cycles %0d",
                 tests_run, tests_failed, checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
